//--- exe_config.svh
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// datapath and address width
`define EXE_DATA_WIDTH 32

// register number width
`define EXE_REG_ADDR_WIDTH 5

// immediate field from decode
`define EXE_IMM_WIDTH 16

// one strobe per byte lane
`define EXE_STRB_WIDTH 4

// shift amount sits in imm[10:6]
`define EXE_SA_LSB 6
`define EXE_SA_MSB 10

`endif

//--- exe_pkg.sv
`default_nettype none

`include "exe_config.svh"

package exe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RS = 2'd0,
        SRC1_SA = 2'd1,    // shift amount field of imm
        SRC1_PC = 2'd2     // link address path
    } src1_sel_e;

    typedef enum logic [1:0] {
        SRC2_RT   = 2'd0,
        SRC2_SIMM = 2'd1,
        SRC2_ZIMM = 2'd2,
        SRC2_8    = 2'd3   // pc + 8 for jal/jalr
    } src2_sel_e;

    typedef enum logic [2:0] {
        HILO_NONE  = 3'd0,
        HILO_MULT  = 3'd1,
        HILO_MULTU = 3'd2,
        HILO_MTHI  = 3'd3,
        HILO_MTLO  = 3'd4,
        HILO_MFHI  = 3'd5,
        HILO_MFLO  = 3'd6
    } hilo_op_e;

    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LW   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LHU  = 4'd3,
        MEM_LB   = 4'd4,
        MEM_LBU  = 4'd5,
        MEM_SW   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SB   = 4'd8
    } mem_op_e;

    // cause register encodings
    typedef enum logic [4:0] {
        EXC_NONE = 5'h00,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_OV   = 5'h0c
    } excode_e;

    typedef struct packed {
        alu_op_e                        alu_op;
        src1_sel_e                      src1_sel;
        src2_sel_e                      src2_sel;
        logic                           ov_en;     // add/sub trap on overflow
        hilo_op_e                       hilo_op;
        mem_op_e                        mem_op;
        logic                           gr_we;
        logic [`EXE_REG_ADDR_WIDTH-1:0] dest;
        logic [`EXE_IMM_WIDTH-1:0]      imm;
        logic [`EXE_DATA_WIDTH-1:0]     rs_value;
        logic [`EXE_DATA_WIDTH-1:0]     rt_value;
        logic [`EXE_DATA_WIDTH-1:0]     pc;
    } exe_issue_t;

    typedef struct packed {
        logic [`EXE_DATA_WIDTH-1:0]     pc;
        logic [`EXE_DATA_WIDTH-1:0]     result;    // also the access address
        logic [`EXE_REG_ADDR_WIDTH-1:0] dest;
        logic                           gr_we;
        mem_op_e                        mem_op;
        logic                           ex;
        excode_e                        excode;
        logic [`EXE_DATA_WIDTH-1:0]     badvaddr;
    } exe_result_t;

endpackage

`default_nettype wire

//--- mem_pkg.sv
`default_nettype none

`include "exe_config.svh"

package mem_pkg;

    // matches the size field of the sram-like bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic                       wr;       // 1 for store
        mem_size_e                  size;
        logic [`EXE_STRB_WIDTH-1:0] wstrb;    // zero on loads
        logic [`EXE_DATA_WIDTH-1:0] addr;
        logic [`EXE_DATA_WIDTH-1:0] wdata;
    } data_req_t;

endpackage

`default_nettype wire

//--- exe_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_alu (
    input  wire exe_pkg::alu_op_e              op,
    input  wire logic [`EXE_DATA_WIDTH-1:0]    src1,
    input  wire logic [`EXE_DATA_WIDTH-1:0]    src2,
    input  wire logic                          ov_en,
    output logic      [`EXE_DATA_WIDTH-1:0]    result,
    output logic                               overflow
);

    localparam int W       = `EXE_DATA_WIDTH;
    localparam int SHAMT_W = $clog2(W);
    localparam int HALF_W  = W / 2;

    logic               do_sub;
    logic [W-1:0]       adder_b;
    logic [W:0]         adder_sum;    // msb is carry out
    logic               add_ov;
    logic               signed_lt;
    logic               unsigned_lt;
    logic [SHAMT_W-1:0] shamt;

    // one adder serves add, sub and both compares
    assign do_sub = (op == exe_pkg::ALU_SUB) || (op == exe_pkg::ALU_SLT) ||
                    (op == exe_pkg::ALU_SLTU);
    assign adder_b   = do_sub ? ~src2 : src2;
    assign adder_sum = {1'b0, src1} + {1'b0, adder_b} + {{W{1'b0}}, do_sub};

    assign add_ov = (src1[W-1] == adder_b[W-1]) && (adder_sum[W-1] != src1[W-1]);
    assign signed_lt = (src1[W-1] & ~src2[W-1]) |
                       (~(src1[W-1] ^ src2[W-1]) & adder_sum[W-1]);
    assign unsigned_lt = ~adder_sum[W];    // no carry means borrow

    assign overflow = ov_en && add_ov &&
                      ((op == exe_pkg::ALU_ADD) || (op == exe_pkg::ALU_SUB));

    assign shamt = src1[SHAMT_W-1:0];

    always_comb begin
        case (op)
            exe_pkg::ALU_ADD,
            exe_pkg::ALU_SUB:  result = adder_sum[W-1:0];
            exe_pkg::ALU_SLT:  result = {{(W-1){1'b0}}, signed_lt};
            exe_pkg::ALU_SLTU: result = {{(W-1){1'b0}}, unsigned_lt};
            exe_pkg::ALU_AND:  result = src1 & src2;
            exe_pkg::ALU_NOR:  result = ~(src1 | src2);
            exe_pkg::ALU_OR:   result = src1 | src2;
            exe_pkg::ALU_XOR:  result = src1 ^ src2;
            exe_pkg::ALU_SLL:  result = src2 << shamt;
            exe_pkg::ALU_SRL:  result = src2 >> shamt;
            exe_pkg::ALU_SRA:  result = $signed(src2) >>> shamt;
            exe_pkg::ALU_LUI:  result = {src2[HALF_W-1:0], {HALF_W{1'b0}}};
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- exe_hilo.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_hilo (
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire exe_pkg::hilo_op_e             op,
    input  wire logic [`EXE_DATA_WIDTH-1:0]    rs_value,
    input  wire logic [`EXE_DATA_WIDTH-1:0]    rt_value,
    input  wire logic                          commit,
    output logic      [`EXE_DATA_WIDTH-1:0]    read_value
);

    localparam int W = `EXE_DATA_WIDTH;

    logic [W-1:0]          hi;
    logic [W-1:0]          lo;
    logic                  is_signed;
    logic signed [W:0]     mul_a;
    logic signed [W:0]     mul_b;
    logic signed [2*W+1:0] product;

    // extend by one bit so a single signed multiplier covers mult and multu
    assign is_signed = (op == exe_pkg::HILO_MULT);
    assign mul_a     = {is_signed & rs_value[W-1], rs_value};
    assign mul_b     = {is_signed & rt_value[W-1], rt_value};
    assign product   = mul_a * mul_b;

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (op)
                exe_pkg::HILO_MULT,
                exe_pkg::HILO_MULTU: begin
                    hi <= product[2*W-1:W];
                    lo <= product[W-1:0];
                end
                exe_pkg::HILO_MTHI: hi <= rs_value;
                exe_pkg::HILO_MTLO: lo <= rs_value;
                default: ;
            endcase
        end
    end

    assign read_value = (op == exe_pkg::HILO_MFHI) ? hi : lo;

endmodule

`default_nettype wire

//--- exe_mem_format.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_mem_format (
    input  wire exe_pkg::mem_op_e              op,
    input  wire logic [`EXE_DATA_WIDTH-1:0]    addr,
    input  wire logic [`EXE_DATA_WIDTH-1:0]    rt_value,
    output logic                               is_store,
    output logic                               is_load,
    output logic                               misaligned_load,
    output logic                               misaligned_store,
    output mem_pkg::mem_size_e                 size,
    output logic      [`EXE_STRB_WIDTH-1:0]    wstrb,
    output logic      [`EXE_DATA_WIDTH-1:0]    wdata
);

    localparam int W      = `EXE_DATA_WIDTH;
    localparam int STRB_W = `EXE_STRB_WIDTH;
    localparam int HALF_S = STRB_W / 2;

    logic misaligned;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        size     = mem_pkg::SIZE_WORD;
        wstrb    = '0;
        wdata    = rt_value;
        case (op)
            exe_pkg::MEM_LW: begin
                is_load = 1'b1;
            end
            exe_pkg::MEM_LH,
            exe_pkg::MEM_LHU: begin
                is_load = 1'b1;
                size    = mem_pkg::SIZE_HALF;
            end
            exe_pkg::MEM_LB,
            exe_pkg::MEM_LBU: begin
                is_load = 1'b1;
                size    = mem_pkg::SIZE_BYTE;
            end
            exe_pkg::MEM_SW: begin
                is_store = 1'b1;
                wstrb    = '1;
            end
            exe_pkg::MEM_SH: begin
                is_store = 1'b1;
                size     = mem_pkg::SIZE_HALF;
                wdata    = {2{rt_value[W/2-1:0]}};    // same half in both lanes
                wstrb    = addr[1] ? {{HALF_S{1'b1}}, {HALF_S{1'b0}}}
                                   : {{HALF_S{1'b0}}, {HALF_S{1'b1}}};
            end
            exe_pkg::MEM_SB: begin
                is_store = 1'b1;
                size     = mem_pkg::SIZE_BYTE;
                wdata    = {STRB_W{rt_value[7:0]}};
                wstrb    = STRB_W'(1) << addr[1:0];    // one hot on byte lane
            end
            default: ;
        endcase
    end

    // byte accesses are never misaligned
    always_comb begin
        case (size)
            mem_pkg::SIZE_WORD: misaligned = (addr[1:0] != 2'b00);
            mem_pkg::SIZE_HALF: misaligned = addr[0];
            default:            misaligned = 1'b0;
        endcase
    end

    assign misaligned_load  = is_load & misaligned;
    assign misaligned_store = is_store & misaligned;

endmodule

`default_nettype wire

//--- exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_stage (
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  issue_valid,
    input  wire exe_pkg::exe_issue_t   issue,
    output logic                       issue_allowin,
    input  wire logic                  ms_allowin,
    output logic                       result_valid,
    output exe_pkg::exe_result_t       result,
    output logic                       data_req_valid,
    output mem_pkg::data_req_t         data_req,
    input  wire logic                  data_addr_ok
);

    localparam int W     = `EXE_DATA_WIDTH;
    localparam int IMM_W = `EXE_IMM_WIDTH;
    localparam int SA_W  = `EXE_SA_MSB - `EXE_SA_LSB + 1;

    logic                       es_valid;
    exe_pkg::exe_issue_t        es_issue;
    logic                       ready_go;
    logic                       commit;
    logic [W-1:0]               alu_src1;
    logic [W-1:0]               alu_src2;
    logic [W-1:0]               alu_result;
    logic                       overflow;
    logic [W-1:0]               hilo_value;
    logic                       is_load;
    logic                       is_store;
    logic                       adel;
    logic                       ades;
    logic                       addr_error;
    mem_pkg::mem_size_e         mem_size;
    logic [`EXE_STRB_WIDTH-1:0] mem_wstrb;
    logic [W-1:0]               mem_wdata;
    exe_pkg::excode_e           excode;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (issue_allowin) begin
            es_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid && issue_allowin) begin
            es_issue <= issue;
        end
    end

    always_comb begin
        case (es_issue.src1_sel)
            exe_pkg::SRC1_SA: alu_src1 = {{(W-SA_W){1'b0}}, es_issue.imm[`EXE_SA_MSB:`EXE_SA_LSB]};
            exe_pkg::SRC1_PC: alu_src1 = es_issue.pc;
            default:          alu_src1 = es_issue.rs_value;
        endcase
        case (es_issue.src2_sel)
            exe_pkg::SRC2_SIMM: alu_src2 = {{(W-IMM_W){es_issue.imm[IMM_W-1]}}, es_issue.imm};
            exe_pkg::SRC2_ZIMM: alu_src2 = {{(W-IMM_W){1'b0}}, es_issue.imm};
            exe_pkg::SRC2_8:    alu_src2 = W'(8);
            default:            alu_src2 = es_issue.rt_value;
        endcase
    end

    exe_alu u_alu (
        .op       (es_issue.alu_op),
        .src1     (alu_src1),
        .src2     (alu_src2),
        .ov_en    (es_issue.ov_en),
        .result   (alu_result),
        .overflow (overflow)
    );

    exe_hilo u_hilo (
        .clk        (clk),
        .reset      (reset),
        .op         (es_issue.hilo_op),
        .rs_value   (es_issue.rs_value),
        .rt_value   (es_issue.rt_value),
        .commit     (commit),
        .read_value (hilo_value)
    );

    exe_mem_format u_mem_format (
        .op               (es_issue.mem_op),
        .addr             (alu_result),
        .rt_value         (es_issue.rt_value),
        .is_store         (is_store),
        .is_load          (is_load),
        .misaligned_load  (adel),
        .misaligned_store (ades),
        .size             (mem_size),
        .wstrb            (mem_wstrb),
        .wdata            (mem_wdata)
    );

    assign addr_error = adel | ades;

    // ov wins over address errors
    assign excode = overflow ? exe_pkg::EXC_OV   :
                    ades     ? exe_pkg::EXC_ADES :
                    adel     ? exe_pkg::EXC_ADEL : exe_pkg::EXC_NONE;

    // faulting accesses never reach memory
    assign data_req_valid = es_valid && (is_load || is_store) && !addr_error && ms_allowin;
    assign ready_go       = !(is_load || is_store) || addr_error ||
                            (data_req_valid && data_addr_ok);
    assign issue_allowin  = !es_valid || (ready_go && ms_allowin);
    assign result_valid   = es_valid && ready_go;
    assign commit         = result_valid && ms_allowin;    // leaves this edge

    assign data_req.wr    = is_store;
    assign data_req.size  = mem_size;
    assign data_req.wstrb = mem_wstrb;
    assign data_req.addr  = alu_result;
    assign data_req.wdata = mem_wdata;

    assign result.pc       = es_issue.pc;
    assign result.result   = (es_issue.hilo_op == exe_pkg::HILO_MFHI ||
                              es_issue.hilo_op == exe_pkg::HILO_MFLO) ? hilo_value : alu_result;
    assign result.dest     = es_issue.dest;
    assign result.gr_we    = es_issue.gr_we;
    assign result.mem_op   = es_issue.mem_op;
    assign result.ex       = (excode != exe_pkg::EXC_NONE);
    assign result.excode   = excode;
    assign result.badvaddr = addr_error ? alu_result : '0;

endmodule

`default_nettype wire

//--- tb_exe_checks.svh
`ifndef TB_EXE_CHECKS_SVH
`define TB_EXE_CHECKS_SVH

int value_errors = 0;
int other_errors = 0;

task automatic check_result(input exe_pkg::exe_result_t got,
                            input exe_pkg::exe_result_t want);
    if (got !== want) begin
        value_errors++;
        $display("Error at %0t: result mismatch for pc %h (got / expected)", $time, want.pc);
        $display("    result %h / %h  excode %0h / %0h  badvaddr %h / %h",
                 got.result, want.result, got.excode, want.excode,
                 got.badvaddr, want.badvaddr);
        $display("    pc %h  dest %0d / %0d  gr_we %b / %b  mem_op %0d / %0d  ex %b / %b",
                 got.pc, got.dest, want.dest, got.gr_we, want.gr_we,
                 got.mem_op, want.mem_op, got.ex, want.ex);
    end
endtask

task automatic check_req(input mem_pkg::data_req_t got,
                         input mem_pkg::data_req_t want);
    mem_pkg::data_req_t seen;
    seen = got;
    if (!want.wr) begin
        seen.wdata = want.wdata;    // data lanes unused on loads
    end
    if (seen !== want) begin
        value_errors++;
        $display("Error at %0t: request mismatch for address %h (got / expected)",
                 $time, want.addr);
        $display("    wr %b / %b  size %0d / %0d  wstrb %b / %b  addr %h / %h  wdata %h / %h",
                 got.wr, want.wr, got.size, want.size, got.wstrb, want.wstrb,
                 got.addr, want.addr, got.wdata, want.wdata);
    end
endtask

`endif

//--- tb_exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module tb_exe_stage;

    localparam int          LINE_WORDS      = 9;
    localparam int          MAX_LINES       = 64;
    localparam int          CYCLES_PER_LINE = 64;
    localparam logic [31:0] END_MARK        = 32'hffffffff;

    logic                 clk;
    logic                 reset;
    logic                 issue_valid;
    exe_pkg::exe_issue_t  issue;
    logic                 issue_allowin;
    logic                 ms_allowin;
    logic                 result_valid;
    exe_pkg::exe_result_t result;
    logic                 data_req_valid;
    mem_pkg::data_req_t   data_req;
    logic                 data_addr_ok;

    logic [31:0]          trace_mem [0:LINE_WORDS*MAX_LINES-1];
    int                   line_count;
    int                   results_seen;
    int                   cycle_count;
    int                   timeout_limit;
    exe_pkg::exe_result_t exp_results [$];
    mem_pkg::data_req_t   exp_reqs [$];

    `include "tb_exe_checks.svh"

    exe_stage DUT (
        .clk            (clk),
        .reset          (reset),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .issue_allowin  (issue_allowin),
        .ms_allowin     (ms_allowin),
        .result_valid   (result_valid),
        .result         (result),
        .data_req_valid (data_req_valid),
        .data_req       (data_req),
        .data_addr_ok   (data_addr_ok)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] word_at(input int idx, input int col);
        return trace_mem[idx*LINE_WORDS + col];
    endfunction

    function automatic exe_pkg::exe_issue_t issue_from_line(input int idx);
        exe_pkg::exe_issue_t it;
        logic [31:0]         ctrl;
        logic [31:0]         dest_imm;
        ctrl        = word_at(idx, 0);
        dest_imm    = word_at(idx, 1);
        it.alu_op   = exe_pkg::alu_op_e'(ctrl[31:28]);
        it.src1_sel = exe_pkg::src1_sel_e'(ctrl[25:24]);
        it.src2_sel = exe_pkg::src2_sel_e'(ctrl[21:20]);
        it.ov_en    = ctrl[16];
        it.hilo_op  = exe_pkg::hilo_op_e'(ctrl[14:12]);
        it.mem_op   = exe_pkg::mem_op_e'(ctrl[11:8]);
        it.gr_we    = ctrl[4];
        it.dest     = dest_imm[20:16];
        it.imm      = dest_imm[15:0];
        it.rs_value = word_at(idx, 2);
        it.rt_value = word_at(idx, 3);
        it.pc       = word_at(idx, 4);
        return it;
    endfunction

    function automatic exe_pkg::exe_result_t result_from_line(input int idx);
        exe_pkg::exe_issue_t  it;
        exe_pkg::exe_result_t r;
        logic [31:0]          flags;
        it         = issue_from_line(idx);
        flags      = word_at(idx, 6);
        r.pc       = it.pc;
        r.result   = word_at(idx, 5);
        r.dest     = it.dest;
        r.gr_we    = it.gr_we;
        r.mem_op   = it.mem_op;
        r.excode   = exe_pkg::excode_e'(flags[20:16]);
        r.ex       = (r.excode != exe_pkg::EXC_NONE);
        r.badvaddr = word_at(idx, 7);
        return r;
    endfunction

    function automatic mem_pkg::data_req_t req_from_line(input int idx);
        mem_pkg::data_req_t q;
        logic [31:0]        flags;
        flags   = word_at(idx, 6);
        q.wr    = flags[8];
        q.size  = mem_pkg::mem_size_e'(flags[5:4]);
        q.wstrb = flags[3:0];
        q.addr  = word_at(idx, 5);    // address is the alu sum
        q.wdata = word_at(idx, 8);
        return q;
    endfunction

    // random back-pressure from memory stage and bus
    initial begin
        ms_allowin   = 1'b0;
        data_addr_ok = 1'b0;
        void'($urandom(32'hf55c));
        forever begin
            @(posedge clk);
            ms_allowin   <= ($urandom % 10) < 7;
            data_addr_ok <= ($urandom % 10) < 7;
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (data_req_valid && data_addr_ok) begin
                if (exp_reqs.size() == 0) begin
                    other_errors++;
                    $display("Unexpected memory request at %0t to address %h",
                             $time, data_req.addr);
                end else begin
                    check_req(data_req, exp_reqs.pop_front());
                end
            end
            if (result_valid && ms_allowin) begin
                if (exp_results.size() == 0) begin
                    other_errors++;
                    $display("Extra result at %0t for pc %h", $time, result.pc);
                end else begin
                    check_result(result, exp_results.pop_front());
                end
                results_seen++;
            end
        end
    end

    initial begin
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d results seen",
                 cycle_count, results_seen, line_count);
        $display("Checks failed");
        $finish;
    end

    initial begin
        reset         = 1'b1;
        issue_valid   = 1'b0;
        issue         = '0;
        results_seen  = 0;
        cycle_count   = 0;
        timeout_limit = 0;
        line_count    = 0;
        $readmemh("exe_trace.txt", trace_mem);
        while (line_count < MAX_LINES && word_at(line_count, 0) != END_MARK) begin
            line_count++;
        end
        if (line_count == MAX_LINES || line_count == 0) begin
            other_errors++;
            $display("Trace file is empty or has no end marker");
            line_count = 0;
        end
        timeout_limit = line_count * CYCLES_PER_LINE + 100;
        for (int i = 0; i < line_count; i++) begin
            exe_pkg::exe_result_t want;
            want = result_from_line(i);
            exp_results.push_back(want);
            // faulting accesses must not reach the bus
            if (want.mem_op != exe_pkg::MEM_NONE && want.excode == exe_pkg::EXC_NONE) begin
                exp_reqs.push_back(req_from_line(i));
            end
        end

        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < line_count; i++) begin
            issue_valid <= 1'b1;
            issue       <= issue_from_line(i);
            @(posedge clk);
            while (!issue_allowin) begin
                @(posedge clk);
            end
        end
        issue_valid <= 1'b0;
        while (results_seen < line_count) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (exp_reqs.size() != 0) begin
            other_errors++;
            $display("%0d expected memory requests never appeared", exp_reqs.size());
        end

        $display("Closing: %0d lines, %0d results, %0d value errors, %0d other errors",
                 line_count, results_seen, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exe_trace.txt
// ctrl nibbles: alu src1 src2 ov_en hilo mem gr_we 0 | dest_imm: dest[20:16] imm[15:0] | rs rt pc
// expected: result, flags (excode[20:16] wr[8] size[5:4] wstrb[3:0]), badvaddr, wdata
00000010 00080000 00000005 00000007 bfc00000 0000000c 00000000 00000000 00000000
00110010 0009fffc 00000010 00000000 bfc00004 0000000c 00000000 00000000 00000000
00010010 000a0000 7fffffff 00000001 bfc00008 80000000 000c0000 00000000 00000000
10010010 000b0000 00000003 00000005 bfc0000c fffffffe 00000000 00000000 00000000
10010010 000c0000 80000000 00000001 bfc00010 7fffffff 000c0000 00000000 00000000
20000010 000d0000 ffffffff 00000001 bfc00014 00000001 00000000 00000000 00000000
30100010 000e8000 00001234 00000000 bfc00018 00000001 00000000 00000000 00000000
40000010 000f0000 f0f0f0f0 ff00ff00 bfc0001c f000f000 00000000 00000000 00000000
40200010 0010ffff 12345678 00000000 bfc00020 00005678 00000000 00000000 00000000
50000010 00110000 f0f0f0f0 0f0f0000 bfc00024 00000f0f 00000000 00000000 00000000
60200010 00128001 10000000 00000000 bfc00028 10008001 00000000 00000000 00000000
70000010 00130000 aaaa5555 ffff0000 bfc0002c 55555555 00000000 00000000 00000000
81000010 00140100 00000000 0000000f bfc00030 000000f0 00000000 00000000 00000000
91000010 00150200 00000000 80000000 bfc00034 00800000 00000000 00000000 00000000
a1000010 001607c0 00000000 80000000 bfc00038 ffffffff 00000000 00000000 00000000
a0000010 00170000 00000024 f0000000 bfc0003c ff000000 00000000 00000000 00000000
b0200010 00181234 00000000 00000000 bfc00040 12340000 00000000 00000000 00000000
02300010 001f0000 00000000 00000000 bfc00044 bfc0004c 00000000 00000000 00000000
00001000 00000000 fffffffe 00000003 bfc00048 00000001 00000000 00000000 00000000
00005010 00020000 00000000 00000000 bfc0004c ffffffff 00000000 00000000 00000000
00006010 00030000 00000000 00000000 bfc00050 fffffffa 00000000 00000000 00000000
00002000 00000000 fffffffe 00000003 bfc00054 00000001 00000000 00000000 00000000
00005010 00040000 00000000 00000000 bfc00058 00000002 00000000 00000000 00000000
00003000 00000000 13579bdf 00000000 bfc0005c 13579bdf 00000000 00000000 00000000
00004000 00000000 2468ace0 00000000 bfc00060 2468ace0 00000000 00000000 00000000
00005010 00050000 00000000 00000000 bfc00064 13579bdf 00000000 00000000 00000000
00006010 00060000 00000000 00000000 bfc00068 2468ace0 00000000 00000000 00000000
00100600 00000004 00001000 deadbeef bfc0006c 00001004 0000012f 00000000 deadbeef
00100700 00000002 00001000 0000cafe bfc00070 00001002 0000011c 00000000 cafecafe
00100700 00000000 00001000 5555abcd bfc00074 00001000 00000113 00000000 abcdabcd
00100800 00000001 00001000 000000a5 bfc00078 00001001 00000102 00000000 a5a5a5a5
00100800 00000003 00001000 1234565a bfc0007c 00001003 00000108 00000000 5a5a5a5a
00100110 0008fff8 00002008 00000000 bfc00080 00002000 00000020 00000000 00000000
00100210 00090002 00002000 00000000 bfc00084 00002002 00000010 00000000 00000000
00100510 000a0003 00002000 00000000 bfc00088 00002003 00000000 00000000 00000000
00100110 000b0002 00002000 00000000 bfc0008c 00002002 00040000 00002002 00000000
00100210 000c0001 00002000 00000000 bfc00090 00002001 00040000 00002001 00000000
00100600 00000001 00001000 11111111 bfc00094 00001001 00050000 00001001 00000000
00100700 00000003 00001000 22222222 bfc00098 00001003 00050000 00001003 00000000
00100110 000d0000 00003000 00000000 bfc0009c 00003000 00000020 00000000 00000000
ffffffff // end of trace

//--- verilog.f
+incdir+.
exe_pkg.sv
mem_pkg.sv
exe_alu.sv
exe_hilo.sv
exe_mem_format.sv
exe_stage.sv
tb_exe_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_exe_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
